// File: include/rv5_cfg.svh
`ifndef RV5_CFG_SVH
`define RV5_CFG_SVH

// datapath width in bits
`define RV5_XLEN 32

// architectural register count
`define RV5_NREGS 32

`define RV5_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV5_NOP 32'h0000_0013

`endif

// File: hw/rv5_pkg.sv
`include "rv5_cfg.svh"

package rv5_pkg;

    typedef logic [`RV5_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV5_NREGS)-1:0] regAddr_t;

    // alu function codes
    typedef logic [2:0] aluOp_t;
    localparam aluOp_t ALU_ADD   = 3'd0;
    localparam aluOp_t ALU_SUB   = 3'd1;
    localparam aluOp_t ALU_AND   = 3'd2;
    localparam aluOp_t ALU_OR    = 3'd3;
    localparam aluOp_t ALU_XOR   = 3'd4;
    localparam aluOp_t ALU_SLT   = 3'd5;
    localparam aluOp_t ALU_PASS2 = 3'd6;

    // next pc source
    typedef logic [1:0] pcSel_t;
    localparam pcSel_t PC_SEQ    = 2'd0;
    localparam pcSel_t PC_BR_JAL = 2'd1;
    localparam pcSel_t PC_JALR   = 2'd2;

    // first alu operand
    typedef logic op1Sel_t;
    localparam op1Sel_t OP1_RS1 = 1'b0;
    localparam op1Sel_t OP1_PC  = 1'b1;

    // writeback source picked in the memory stage
    typedef logic memWbSel_t;
    localparam memWbSel_t WB_EXE = 1'b0;
    localparam memWbSel_t WB_MEM = 1'b1;

    // control fields carried down the pipe, all zero is a bubble
    typedef struct packed {
        pcSel_t     pcSel;
        logic       isBeq;
        logic       isBne;
        aluOp_t     aluOp;
        logic       exeLink;
        memWbSel_t  memWbSel;
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        regAddr_t   rd;
    } ctrlBundle_t;

endpackage

// File: hw/instrDecoder.sv
module instrDecoder (
    input  rv5_pkg::word_t      instruction,
    output rv5_pkg::ctrlBundle_t ctrl,
    output rv5_pkg::op1Sel_t    op1Sel,
    output logic                useImm,
    output rv5_pkg::word_t      imm
);
    import rv5_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regAddr_t   rdField;
    logic       writesRd;
    word_t      iImm;
    word_t      sImm;
    word_t      bImm;
    word_t      uImm;
    word_t      jImm;

    assign opcode  = instruction[6:0];
    assign funct3  = instruction[14:12];
    assign funct7  = instruction[31:25];
    assign rdField = instruction[11:7];

    // sign-extended immediates for each format
    assign iImm = {{20{instruction[31]}}, instruction[31:20]};
    assign sImm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign bImm = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign uImm = {instruction[31:12], 12'b0};
    assign jImm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        ctrl.pcSel = PC_SEQ;
        ctrl.aluOp = ALU_ADD;
        ctrl.memWbSel = WB_EXE;
        op1Sel = OP1_RS1;
        useImm = 1'b0;
        imm = iImm;
        writesRd = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                useImm = 1'b1;
                writesRd = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluOp = ALU_ADD;
                    3'b010: ctrl.aluOp = ALU_SLT;
                    3'b100: ctrl.aluOp = ALU_XOR;
                    3'b110: ctrl.aluOp = ALU_OR;
                    3'b111: ctrl.aluOp = ALU_AND;
                    // shifts are not supported
                    default: writesRd = 1'b0;
                endcase
            end
            OPC_OP: begin
                writesRd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.aluOp = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.aluOp = ALU_SUB;
                    {7'b0000000, 3'b010}: ctrl.aluOp = ALU_SLT;
                    {7'b0000000, 3'b100}: ctrl.aluOp = ALU_XOR;
                    {7'b0000000, 3'b110}: ctrl.aluOp = ALU_OR;
                    {7'b0000000, 3'b111}: ctrl.aluOp = ALU_AND;
                    default: writesRd = 1'b0;
                endcase
            end
            OPC_LUI: begin
                useImm = 1'b1;
                imm = uImm;
                ctrl.aluOp = ALU_PASS2;
                writesRd = 1'b1;
            end
            OPC_AUIPC: begin
                op1Sel = OP1_PC;
                useImm = 1'b1;
                imm = uImm;
                writesRd = 1'b1;
            end
            OPC_LOAD: begin
                // word access only
                if (funct3 == 3'b010) begin
                    useImm = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.memWbSel = WB_MEM;
                    writesRd = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    useImm = 1'b1;
                    imm = sImm;
                    ctrl.memWrite = 1'b1;
                end
            end
            OPC_BRANCH: begin
                // op2 carries the offset, rs2 travels separately for the compare
                useImm = 1'b1;
                imm = bImm;
                case (funct3)
                    3'b000: begin
                        ctrl.pcSel = PC_BR_JAL;
                        ctrl.isBeq = 1'b1;
                    end
                    3'b001: begin
                        ctrl.pcSel = PC_BR_JAL;
                        ctrl.isBne = 1'b1;
                    end
                    default: ctrl.pcSel = PC_SEQ;
                endcase
            end
            OPC_JAL: begin
                useImm = 1'b1;
                imm = jImm;
                ctrl.pcSel = PC_BR_JAL;
                ctrl.exeLink = 1'b1;
                writesRd = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    useImm = 1'b1;
                    ctrl.pcSel = PC_JALR;
                    ctrl.exeLink = 1'b1;
                    writesRd = 1'b1;
                end
            end
            default: writesRd = 1'b0;
        endcase
        // x0 destinations never write, so a nop decodes to a bubble
        ctrl.regWrite = writesRd && (rdField != '0);
        ctrl.rd = ctrl.regWrite ? rdField : '0;
    end

endmodule

// File: hw/regFile.sv
`include "rv5_cfg.svh"

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  rv5_pkg::regAddr_t rs1Addr,
    input  rv5_pkg::regAddr_t rs2Addr,
    input  rv5_pkg::regAddr_t wrAddr,
    input  rv5_pkg::regAddr_t debugAddr,
    input  rv5_pkg::word_t    wrData,
    input  logic              wrEnable,
    output rv5_pkg::word_t    rs1Data,
    output rv5_pkg::word_t    rs2Data,
    output rv5_pkg::word_t    debugData
);
    import rv5_pkg::*;

    word_t regs [`RV5_NREGS];

    // x0 is cleared here and never written afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV5_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEnable && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // no write-through, decode reads the old value on a same-cycle write
    assign rs1Data   = regs[rs1Addr];
    assign rs2Data   = regs[rs2Addr];
    assign debugData = regs[debugAddr];

endmodule

// File: hw/hazardUnit.sv
module hazardUnit (
    input  rv5_pkg::regAddr_t ifRs1,
    input  rv5_pkg::regAddr_t ifRs2,
    input  rv5_pkg::regAddr_t decRd,
    input  rv5_pkg::regAddr_t exeRd,
    input  rv5_pkg::regAddr_t memRd,
    input  rv5_pkg::regAddr_t wbRd,
    input  logic              decRegWrite,
    input  logic              exeRegWrite,
    input  logic              memRegWrite,
    input  logic              wbRegWrite,
    input  logic              redirect,
    output logic              pcWriteEnable,
    output logic              ifKill,
    output logic              decKill
);
    import rv5_pkg::*;

    logic decHit;
    logic exeHit;
    logic memHit;
    logic wbHit;
    logic stall;

    // one in-flight writer against both fetch sources
    function automatic logic readsDest(regAddr_t rs1, regAddr_t rs2, regAddr_t rd, logic we);
        logic live;
        live = we && (rd != '0);
        return live && ((rs1 == rd) || (rs2 == rd));
    endfunction

    assign decHit = readsDest(ifRs1, ifRs2, decRd, decRegWrite);
    assign exeHit = readsDest(ifRs1, ifRs2, exeRd, exeRegWrite);
    assign memHit = readsDest(ifRs1, ifRs2, memRd, memRegWrite);
    assign wbHit  = readsDest(ifRs1, ifRs2, wbRd, wbRegWrite);

    // no forwarding, so wait until the writer has left writeback
    assign stall = decHit || exeHit || memHit || wbHit;

    // a taken redirect wins over a stall and flushes both younger slots
    assign pcWriteEnable = !stall || redirect;
    assign ifKill        = stall || redirect;
    assign decKill       = redirect;

endmodule

// File: hw/executeUnit.sv
module executeUnit (
    input  rv5_pkg::ctrlBundle_t ctrl,
    input  rv5_pkg::word_t       pc,
    input  rv5_pkg::word_t       op1,
    input  rv5_pkg::word_t       op2,
    input  rv5_pkg::word_t       rs2,
    output rv5_pkg::word_t       result,
    output logic                 redirect,
    output rv5_pkg::word_t       redirectTarget
);
    import rv5_pkg::*;

    word_t aluOut;
    word_t linkAddr;
    word_t branchTarget;
    word_t jalrSum;
    word_t jalrTarget;
    logic  isEqual;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:   aluOut = op1 + op2;
            ALU_SUB:   aluOut = op1 - op2;
            ALU_AND:   aluOut = op1 & op2;
            ALU_OR:    aluOut = op1 | op2;
            ALU_XOR:   aluOut = op1 ^ op2;
            ALU_SLT:   aluOut = word_t'($signed(op1) < $signed(op2));
            // lui
            ALU_PASS2: aluOut = op2;
            default:   aluOut = '0;
        endcase
    end

    assign linkAddr = pc + word_t'(4);
    assign result   = ctrl.exeLink ? linkAddr : aluOut;

    // op1 holds rs1 for branches
    assign isEqual = (op1 == rs2);

    assign branchTarget = pc + op2;
    assign jalrSum      = op1 + op2;
    assign jalrTarget   = jalrSum & ~word_t'(1);

    always_comb begin
        case (ctrl.pcSel)
            PC_BR_JAL: begin
                if (ctrl.isBeq) begin
                    redirect = isEqual;
                end else if (ctrl.isBne) begin
                    redirect = !isEqual;
                end else begin
                    // jal
                    redirect = 1'b1;
                end
            end
            PC_JALR: redirect = 1'b1;
            PC_SEQ:  redirect = 1'b0;
            default: redirect = 1'b0;
        endcase
    end

    assign redirectTarget = (ctrl.pcSel == PC_JALR) ? jalrTarget : branchTarget;

endmodule

// File: hw/rv5Pipeline.sv
`include "rv5_cfg.svh"

module rv5Pipeline (
    input  logic              clk,
    input  logic              rst,
    // instruction rom
    output rv5_pkg::word_t    pc,
    input  rv5_pkg::word_t    instruction,
    // data ram
    output rv5_pkg::word_t    memoryAddress,
    output rv5_pkg::word_t    memoryWriteData,
    output logic              memoryReadEnable,
    output logic              memoryWriteEnable,
    input  rv5_pkg::word_t    memoryReadData,
    // register observation
    input  rv5_pkg::regAddr_t regDebugAddr,
    output rv5_pkg::word_t    regDebugData
);
    import rv5_pkg::*;

    // hazard and redirect
    logic        pcWriteEnable;
    logic        ifKill;
    logic        decKill;
    logic        redirect;
    word_t       redirectTarget;
    word_t       pcPlus4;
    word_t       nextPc;

    // decode stage
    word_t       decPc;
    word_t       decInstr;
    ctrlBundle_t decCtrl;
    op1Sel_t     decOp1Sel;
    logic        decUseImm;
    word_t       decImm;
    word_t       rs1Data;
    word_t       rs2Data;
    word_t       decOp1;
    word_t       decOp2;

    // execute stage
    word_t       exePc;
    word_t       exeOp1;
    word_t       exeOp2;
    word_t       exeRs2;
    ctrlBundle_t exeCtrl;
    word_t       exeResult;

    // memory stage
    word_t       memResult;
    word_t       memRs2;
    ctrlBundle_t memCtrl;
    word_t       memWbData;

    // writeback stage
    word_t       wbData;
    ctrlBundle_t wbCtrl;

    hazardUnit u_hazardUnit (
        .ifRs1(instruction[19:15]),
        .ifRs2(instruction[24:20]),
        .decRd(decCtrl.rd),
        .exeRd(exeCtrl.rd),
        .memRd(memCtrl.rd),
        .wbRd(wbCtrl.rd),
        .decRegWrite(decCtrl.regWrite),
        .exeRegWrite(exeCtrl.regWrite),
        .memRegWrite(memCtrl.regWrite),
        .wbRegWrite(wbCtrl.regWrite),
        .redirect(redirect),
        .pcWriteEnable(pcWriteEnable),
        .ifKill(ifKill),
        .decKill(decKill)
    );

    regFile u_regFile (
        .clk(clk),
        .rst(rst),
        .rs1Addr(decInstr[19:15]),
        .rs2Addr(decInstr[24:20]),
        .wrAddr(wbCtrl.rd),
        .debugAddr(regDebugAddr),
        .wrData(wbData),
        .wrEnable(wbCtrl.regWrite),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .debugData(regDebugData)
    );

    // fetch
    assign pcPlus4 = pc + word_t'(4);
    assign nextPc  = redirect ? redirectTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV5_RESET_PC;
        end else if (pcWriteEnable) begin
            pc <= nextPc;
        end
    end

    // decode
    instrDecoder u_instrDecoder (
        .instruction(decInstr),
        .ctrl(decCtrl),
        .op1Sel(decOp1Sel),
        .useImm(decUseImm),
        .imm(decImm)
    );

    assign decOp1 = (decOp1Sel == OP1_PC) ? decPc : rs1Data;
    assign decOp2 = decUseImm ? decImm : rs2Data;

    // execute
    executeUnit u_executeUnit (
        .ctrl(exeCtrl),
        .pc(exePc),
        .op1(exeOp1),
        .op2(exeOp2),
        .rs2(exeRs2),
        .result(exeResult),
        .redirect(redirect),
        .redirectTarget(redirectTarget)
    );

    // memory, ram answers in the same cycle
    assign memoryAddress     = memResult;
    assign memoryWriteData   = memRs2;
    assign memoryReadEnable  = memCtrl.memRead;
    assign memoryWriteEnable = memCtrl.memWrite;
    assign memWbData = (memCtrl.memWbSel == WB_MEM) ? memoryReadData : memResult;

    // stage control, killed slots become a nop or a zero bundle
    always_ff @(posedge clk) begin
        if (rst) begin
            decInstr <= `RV5_NOP;
            exeCtrl  <= '0;
            memCtrl  <= '0;
            wbCtrl   <= '0;
        end else begin
            decInstr <= ifKill ? word_t'(`RV5_NOP) : instruction;
            exeCtrl  <= decKill ? ctrlBundle_t'('0) : decCtrl;
            memCtrl  <= exeCtrl;
            wbCtrl   <= memCtrl;
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        decPc     <= pc;
        exePc     <= decPc;
        exeOp1    <= decOp1;
        exeOp2    <= decOp2;
        exeRs2    <= rs2Data;
        memResult <= exeResult;
        memRs2    <= exeRs2;
        wbData    <= memWbData;
    end

endmodule

// File: testbench/tbClock.sv
module tbClock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

// File: testbench/rv5_sva.sv
module rv5_sva (
    input logic           clk,
    input logic           rst,
    input rv5_pkg::word_t pc,
    input logic           memoryReadEnable,
    input logic           memoryWriteEnable
);
    timeunit 1ns;
    timeprecision 1ps;

    // a memory-stage slot is a load, a store or neither
    assertOneAccess: assert property (@(posedge clk) disable iff (rst)
        !(memoryReadEnable && memoryWriteEnable))
        else $error("memory read and write enables are high together");

    // bundles are cleared by reset
    assertQuietAfterReset: assert property (@(posedge clk)
        rst |=> (!memoryReadEnable && !memoryWriteEnable))
        else $error("memory enable active in the cycle after reset");

    assertPcAligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

bind rv5Pipeline rv5_sva u_rv5_sva (
    .clk(clk),
    .rst(rst),
    .pc(pc),
    .memoryReadEnable(memoryReadEnable),
    .memoryWriteEnable(memoryWriteEnable)
);

// File: testbench/rv5Tb.sv
`include "rv5_cfg.svh"

module rv5Tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv5_pkg::*;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] F7_SUB    = 7'b0100000;

    logic        clk;
    logic        rst;
    word_t       pc;
    word_t       instruction;
    word_t       memoryAddress;
    word_t       memoryWriteData;
    logic        memoryReadEnable;
    logic        memoryWriteEnable;
    word_t       memoryReadData;
    regAddr_t    regDebugAddr;
    word_t       regDebugData;

    logic [31:0] rom [64];
    logic [31:0] ram [64];
    logic [31:0] progWords [$];
    int          loadCount;
    int          seed = 44982;

    tbClock u_tbClock (
        .clk(clk)
    );

    rv5Pipeline u_rv5Pipeline (
        .clk(clk),
        .rst(rst),
        .pc(pc),
        .instruction(instruction),
        .memoryAddress(memoryAddress),
        .memoryWriteData(memoryWriteData),
        .memoryReadEnable(memoryReadEnable),
        .memoryWriteEnable(memoryWriteEnable),
        .memoryReadData(memoryReadData),
        .regDebugAddr(regDebugAddr),
        .regDebugData(regDebugData)
    );

    // rom and ram answer in the same cycle
    assign instruction    = rom[pc[7:2]];
    assign memoryReadData = ram[memoryAddress[7:2]];

    // ram refills with its pattern while reset is held
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= ramFill(i);
            end
            loadCount <= 0;
        end else begin
            if (memoryWriteEnable) begin
                ram[memoryAddress[7:2]] <= memoryWriteData;
            end
            // one read strobe per load in the memory stage
            if (memoryReadEnable) begin
                loadCount <= loadCount + 1;
            end
        end
    end

    function automatic logic [31:0] ramFill(int idx);
        return {16'hDA7A, 2'b00, 6'(idx), 2'b00, ~6'(idx)};
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] immOp(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] regOp(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] upperOp(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] loadOp(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] storeOp(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branchOp(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                             logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jalOp(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalrOp(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic checkReg(input int r, input logic [31:0] expected);
        @(posedge clk);
        regDebugAddr <= 5'(r);
        @(negedge clk);
        checkValue($sformatf("register x%0d", r), expected, regDebugData);
    endtask

    // loads progWords, resets the core and waits for the closing self jump
    task automatic runProgram();
        logic [31:0] endPc;
        int          cycles;
        int          visits;
        endPc = 32'((progWords.size() - 1) * 4);
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < 64; i++) begin
            rom[i] = `RV5_NOP;
        end
        foreach (progWords[i]) begin
            rom[i] = progWords[i];
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkValue("pc in reset", `RV5_RESET_PC, pc);
        checkValue("read enable in reset", 32'd0, 32'(memoryReadEnable));
        checkValue("write enable in reset", 32'd0, 32'(memoryWriteEnable));
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("pc after reset", `RV5_RESET_PC, pc);
        checkValue("read enable after reset", 32'd0, 32'(memoryReadEnable));
        checkValue("write enable after reset", 32'd0, 32'(memoryWriteEnable));
        cycles = 0;
        visits = 0;
        while (visits < 8) begin
            if (cycles >= 500) begin
                $display("timeout: pc never settled on the final jump at %h", endPc);
                $display("Simulation failed");
                $fatal(1, "timeout");
            end
            @(negedge clk);
            cycles++;
            if (pc == endPc) begin
                visits++;
            end
        end
    endtask

    task automatic testAluChain();
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        logic [11:0] d;
        logic [11:0] f;
        logic [19:0] u1;
        logic [19:0] u2;
        logic [31:0] exp [15];
        a = 12'($random(seed));
        b = 12'($random(seed));
        c = 12'($random(seed));
        d = 12'($random(seed));
        f = 12'($random(seed));
        u1 = 20'($random(seed));
        u2 = 20'($random(seed));
        progWords.delete();
        // most instructions read the one before, so they wait on a stall
        progWords.push_back(immOp(F3_ADD, 1, 0, a));
        progWords.push_back(immOp(F3_XOR, 2, 1, b));
        progWords.push_back(immOp(F3_OR, 3, 2, c));
        progWords.push_back(immOp(F3_AND, 4, 3, d));
        progWords.push_back(immOp(F3_SLT, 5, 4, f));
        progWords.push_back(regOp(7'd0, F3_ADD, 6, 1, 2));
        progWords.push_back(regOp(F7_SUB, F3_ADD, 7, 6, 3));
        progWords.push_back(regOp(7'd0, F3_AND, 8, 7, 2));
        progWords.push_back(regOp(7'd0, F3_OR, 9, 8, 4));
        progWords.push_back(regOp(7'd0, F3_XOR, 10, 9, 6));
        progWords.push_back(regOp(7'd0, F3_SLT, 11, 10, 7));
        progWords.push_back(upperOp(OPC_LUI, 12, u1));
        progWords.push_back(upperOp(OPC_AUIPC, 13, u2));
        progWords.push_back(regOp(7'd0, F3_ADD, 14, 12, 13));
        progWords.push_back(jalOp(0, 21'd0));
        exp[0] = 32'd0;
        exp[1] = sext12(a);
        exp[2] = exp[1] ^ sext12(b);
        exp[3] = exp[2] | sext12(c);
        exp[4] = exp[3] & sext12(d);
        exp[5] = ($signed(exp[4]) < $signed(sext12(f))) ? 32'd1 : 32'd0;
        exp[6] = exp[1] + exp[2];
        exp[7] = exp[6] - exp[3];
        exp[8] = exp[7] & exp[2];
        exp[9] = exp[8] | exp[4];
        exp[10] = exp[9] ^ exp[6];
        exp[11] = ($signed(exp[10]) < $signed(exp[7])) ? 32'd1 : 32'd0;
        exp[12] = {u1, 12'h000};
        // auipc sits at word 12
        exp[13] = 32'd48 + {u2, 12'h000};
        exp[14] = exp[12] + exp[13];
        runProgram();
        for (int r = 1; r <= 14; r++) begin
            checkReg(r, exp[r]);
        end
    endtask

    task automatic testReset();
        progWords.delete();
        progWords.push_back(jalOp(0, 21'd0));
        runProgram();
        // values left by the previous program are gone
        for (int r = 0; r < 32; r++) begin
            checkReg(r, 32'd0);
        end
    endtask

    task automatic testStoreLoad();
        logic [11:0] off;
        logic [11:0] val;
        int          idx;
        off = 12'($random(seed)) & 12'h03C;
        val = 12'($random(seed));
        idx = int'((32'h80 + 32'(off)) >> 2);
        progWords.delete();
        progWords.push_back(immOp(F3_ADD, 1, 0, 12'h080));
        progWords.push_back(immOp(F3_ADD, 2, 0, val));
        progWords.push_back(storeOp(2, 1, off));
        progWords.push_back(loadOp(3, 1, off));
        progWords.push_back(loadOp(4, 0, 12'h010));
        progWords.push_back(jalOp(0, 21'd0));
        runProgram();
        checkValue("ram word after store", sext12(val), ram[idx]);
        checkValue("loads seen by ram", 32'd2, 32'(loadCount));
        checkReg(3, sext12(val));
        checkReg(4, ramFill(4));
    endtask

    task automatic testBranches();
        logic beqSame;
        logic bneSame;
        logic beqDiff;
        logic bneDiff;
        beqSame = (5 == 5);
        bneSame = (5 != 5);
        beqDiff = (5 == 7);
        bneDiff = (5 != 7);
        progWords.delete();
        progWords.push_back(immOp(F3_ADD, 1, 0, 12'd5));
        progWords.push_back(immOp(F3_ADD, 2, 0, 12'd5));
        progWords.push_back(immOp(F3_ADD, 3, 0, 12'd7));
        progWords.push_back(branchOp(F3_BEQ, 1, 2, 13'd12));
        progWords.push_back(immOp(F3_ADD, 10, 0, 12'd1));
        progWords.push_back(immOp(F3_ADD, 11, 0, 12'd1));
        progWords.push_back(immOp(F3_ADD, 12, 0, 12'd1));
        progWords.push_back(branchOp(F3_BNE, 1, 2, 13'd12));
        progWords.push_back(immOp(F3_ADD, 13, 0, 12'd1));
        progWords.push_back(immOp(F3_ADD, 14, 0, 12'd1));
        progWords.push_back(branchOp(F3_BEQ, 1, 3, 13'd12));
        progWords.push_back(immOp(F3_ADD, 16, 0, 12'd1));
        progWords.push_back(immOp(F3_ADD, 17, 0, 12'd1));
        progWords.push_back(branchOp(F3_BNE, 1, 3, 13'd12));
        progWords.push_back(immOp(F3_ADD, 18, 0, 12'd1));
        progWords.push_back(immOp(F3_ADD, 19, 0, 12'd1));
        progWords.push_back(immOp(F3_ADD, 20, 0, 12'd1));
        progWords.push_back(jalOp(0, 21'd0));
        runProgram();
        // markers behind a taken branch stay zero
        checkReg(10, beqSame ? 32'd0 : 32'd1);
        checkReg(11, beqSame ? 32'd0 : 32'd1);
        checkReg(12, 32'd1);
        checkReg(13, bneSame ? 32'd0 : 32'd1);
        checkReg(14, bneSame ? 32'd0 : 32'd1);
        checkReg(16, beqDiff ? 32'd0 : 32'd1);
        checkReg(17, beqDiff ? 32'd0 : 32'd1);
        checkReg(18, bneDiff ? 32'd0 : 32'd1);
        checkReg(19, bneDiff ? 32'd0 : 32'd1);
        checkReg(20, 32'd1);
    endtask

    task automatic testJumps();
        progWords.delete();
        progWords.push_back(jalOp(5, 21'd12));
        progWords.push_back(immOp(F3_ADD, 6, 0, 12'd1));
        progWords.push_back(immOp(F3_ADD, 6, 0, 12'd2));
        progWords.push_back(immOp(F3_ADD, 7, 0, 12'd20));
        // 20 + 5 with bit 0 cleared lands on word 6
        progWords.push_back(jalrOp(8, 7, 12'd5));
        progWords.push_back(immOp(F3_ADD, 6, 0, 12'd3));
        progWords.push_back(immOp(F3_ADD, 9, 0, 12'd1));
        progWords.push_back(jalOp(0, 21'd0));
        runProgram();
        checkReg(5, 32'd0 + 32'd4);
        checkReg(6, 32'd0);
        checkReg(7, 32'd20);
        checkReg(8, 32'd16 + 32'd4);
        checkReg(9, 32'd1);
    endtask

    task automatic testZeroReg();
        progWords.delete();
        progWords.push_back(immOp(F3_ADD, 0, 0, 12'h07B));
        progWords.push_back(upperOp(OPC_LUI, 0, 20'hABCDE));
        progWords.push_back(immOp(F3_ADD, 1, 0, 12'd5));
        progWords.push_back(regOp(7'd0, F3_ADD, 2, 0, 1));
        progWords.push_back(jalOp(0, 21'd0));
        runProgram();
        checkReg(0, 32'd0);
        checkReg(1, 32'd5);
        checkReg(2, 32'd5);
    endtask

    initial begin
        rst <= 1'b1;
        regDebugAddr <= '0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = `RV5_NOP;
        end
        testAluChain();
        testReset();
        testStoreLoad();
        testBranches();
        testJumps();
        testZeroReg();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
hw/rv5_pkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/hazardUnit.sv
hw/executeUnit.sv
hw/rv5Pipeline.sv
testbench/tbClock.sv
testbench/rv5_sva.sv
testbench/rv5Tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rv5Tb -f sim.f -o rv5Tb
./obj_dir/rv5Tb
